//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dec
LOG       ?= sim.log
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dec_ctrl.sv
`default_nettype none

module dec_ctrl import dec_pkg::*; (
    input  inst_u      inst_i,
    input  logic       inst_valid_i,
    output imm_fmt_e   imm_fmt_o,
    output alu_op_e    alu_op_o,
    output logic [1:0] mem_size_o,
    output logic       rs1_zero_sel_o,
    output logic       rs2_imm_sel_o,
    output logic       pc_imm_sel_o,
    output logic       pc_alu_sel_o,
    output logic       branch_o,
    output logic       branch_zcmp_o,
    output logic       jump_o,
    output logic       jump_alu_o,
    output logic       mem_req_o,
    output logic       mem_wr_o,
    output logic       mem_sign_ext_o,
    output logic       mem_cal_sel_o,
    output logic       reg_wr_o,
    output logic       ill_inst_o
);

    // base alu op for a funct3 with funct7 at zero
    function automatic alu_op_e base_alu_op(input logic [2:0] funct3);
        alu_op_e op;
        case (funct3)
            FUNCT3_SLL:  op = ALU_SLL;
            FUNCT3_SLT:  op = ALU_SLT;
            FUNCT3_SLTU: op = ALU_SLTU;
            FUNCT3_XOR:  op = ALU_XOR;
            FUNCT3_SRL:  op = ALU_SRL;
            FUNCT3_OR:   op = ALU_OR;
            FUNCT3_AND:  op = ALU_AND;
            default:     op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        imm_fmt_o      = IMM_NONE;
        alu_op_o       = ALU_ADD;
        mem_size_o     = MEM_SIZE_B;
        rs1_zero_sel_o = 1'b0;
        rs2_imm_sel_o  = 1'b0;
        pc_imm_sel_o   = 1'b0;
        pc_alu_sel_o   = 1'b0;
        branch_o       = 1'b0;
        branch_zcmp_o  = 1'b0;
        jump_o         = 1'b0;
        jump_alu_o     = 1'b0;
        mem_req_o      = 1'b0;
        mem_wr_o       = 1'b0;
        mem_sign_ext_o = 1'b0;
        mem_cal_sel_o  = 1'b0;
        reg_wr_o       = 1'b0;
        ill_inst_o     = inst_valid_i && (inst_i.r.quadrant != 2'b11); // compressed space
        if (inst_valid_i) begin
            case (inst_i.r.opcode)
                OP_LOAD: begin
                    imm_fmt_o      = IMM_I;
                    rs1_zero_sel_o = 1'b1;
                    mem_req_o      = 1'b1;
                    mem_cal_sel_o  = 1'b1; // write back load data
                    reg_wr_o       = 1'b1;
                    case (inst_i.r.funct3)
                        FUNCT3_LB: begin
                            mem_size_o     = MEM_SIZE_B;
                            mem_sign_ext_o = 1'b1;
                        end
                        FUNCT3_LH: begin
                            mem_size_o     = MEM_SIZE_H;
                            mem_sign_ext_o = 1'b1;
                        end
                        FUNCT3_LW: begin
                            mem_size_o     = MEM_SIZE_W;
                            mem_sign_ext_o = 1'b1;
                        end
                        FUNCT3_LBU: mem_size_o = MEM_SIZE_B;
                        FUNCT3_LHU: mem_size_o = MEM_SIZE_H;
                        default:    ill_inst_o = 1'b1;
                    endcase
                end
                OP_OP_IMM: begin
                    imm_fmt_o      = IMM_I;
                    rs1_zero_sel_o = 1'b1;
                    reg_wr_o       = 1'b1;
                    case (inst_i.r.funct3)
                        FUNCT3_SLL: begin
                            if (inst_i.r.funct7 == FUNCT7_BASE) alu_op_o = ALU_SLL;
                            else ill_inst_o = 1'b1;
                        end
                        FUNCT3_SRL: begin
                            if (inst_i.r.funct7 == FUNCT7_BASE) alu_op_o = ALU_SRL;
                            else if (inst_i.r.funct7 == FUNCT7_ALT) alu_op_o = ALU_SRA;
                            else ill_inst_o = 1'b1;
                        end
                        default: alu_op_o = base_alu_op(inst_i.r.funct3); // funct7 is imm here
                    endcase
                end
                OP_AUIPC: begin
                    imm_fmt_o      = IMM_U;
                    rs1_zero_sel_o = 1'b1;
                    pc_imm_sel_o   = 1'b1; // pc + imm
                    pc_alu_sel_o   = 1'b1;
                    reg_wr_o       = 1'b1;
                end
                OP_STORE: begin
                    imm_fmt_o      = IMM_S;
                    rs1_zero_sel_o = 1'b1;
                    mem_req_o      = 1'b1;
                    mem_wr_o       = 1'b1;
                    case (inst_i.r.funct3)
                        FUNCT3_SB: mem_size_o = MEM_SIZE_B;
                        FUNCT3_SH: mem_size_o = MEM_SIZE_H;
                        FUNCT3_SW: mem_size_o = MEM_SIZE_W;
                        default:   ill_inst_o = 1'b1;
                    endcase
                end
                OP_OP: begin
                    rs1_zero_sel_o = 1'b1;
                    rs2_imm_sel_o  = 1'b1; // rs2 operand
                    reg_wr_o       = 1'b1;
                    case (inst_i.r.funct7)
                        FUNCT7_BASE: alu_op_o = base_alu_op(inst_i.r.funct3);
                        FUNCT7_ALT: begin
                            if (inst_i.r.funct3 == FUNCT3_ADD) alu_op_o = ALU_SUB;
                            else if (inst_i.r.funct3 == FUNCT3_SRL) alu_op_o = ALU_SRA;
                            else ill_inst_o = 1'b1;
                        end
                        default: ill_inst_o = 1'b1;
                    endcase
                end
                OP_LUI: begin
                    imm_fmt_o = IMM_U;
                    alu_op_o  = ALU_OR; // zero | imm
                    reg_wr_o  = 1'b1;
                end
                OP_BRANCH: begin
                    imm_fmt_o      = IMM_B;
                    rs1_zero_sel_o = 1'b1;
                    rs2_imm_sel_o  = 1'b1;
                    branch_o       = 1'b1;
                    case (inst_i.r.funct3)
                        FUNCT3_BEQ: begin
                            alu_op_o      = ALU_SUB;
                            branch_zcmp_o = 1'b1;
                        end
                        FUNCT3_BNE: alu_op_o = ALU_SUB;
                        FUNCT3_BLT: alu_op_o = ALU_SLT;
                        FUNCT3_BGE: begin
                            alu_op_o      = ALU_SLT;
                            branch_zcmp_o = 1'b1;
                        end
                        FUNCT3_BLTU: alu_op_o = ALU_SLTU;
                        FUNCT3_BGEU: begin
                            alu_op_o      = ALU_SLTU;
                            branch_zcmp_o = 1'b1;
                        end
                        default: ill_inst_o = 1'b1;
                    endcase
                end
                OP_JALR: begin
                    imm_fmt_o      = IMM_I;
                    rs1_zero_sel_o = 1'b1;
                    pc_alu_sel_o   = 1'b1; // link address to rd
                    reg_wr_o       = 1'b1;
                    jump_alu_o     = 1'b1;
                end
                OP_JAL: begin
                    imm_fmt_o      = IMM_J;
                    rs1_zero_sel_o = 1'b1;
                    rs2_imm_sel_o  = 1'b1;
                    pc_alu_sel_o   = 1'b1;
                    reg_wr_o       = 1'b1;
                    jump_o         = 1'b1;
                end
                default: ill_inst_o = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dec_imm.sv
`default_nettype none

module dec_imm import dec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  inst_u            inst_i,
    input  imm_fmt_e         imm_fmt_i,
    output logic [XLEN-1:0]  imm_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign imm_i = XLEN'($signed(inst_i.i.imm11_0));
    assign imm_s = XLEN'($signed({inst_i.s.imm11_5, inst_i.s.imm4_0}));
    // b reuses the s slices, bit 7 moves up to imm[11]
    assign imm_b = XLEN'($signed({inst_i.s.imm11_5[6], inst_i.s.imm4_0[0],
                                  inst_i.s.imm11_5[5:0], inst_i.s.imm4_0[4:1], 1'b0}));
    assign imm_u = XLEN'($signed({inst_i.u.imm31_12, 12'b0}));
    // j is scrambled out of the upper 20 bits
    assign imm_j = XLEN'($signed({inst_i.u.imm31_12[19], inst_i.u.imm31_12[7:0],
                                  inst_i.u.imm31_12[8], inst_i.u.imm31_12[18:9], 1'b0}));

    always_comb begin
        case (imm_fmt_i)
            IMM_I:   imm_o = imm_i;
            IMM_S:   imm_o = imm_s;
            IMM_B:   imm_o = imm_b;
            IMM_U:   imm_o = imm_u;
            IMM_J:   imm_o = imm_j;
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- dec_patterns.txt
# inst     v imm      alu strb sel  xfer mem  wb
# sel=rs1_zero,rs2_imm,pc_imm,pc_alu xfer=branch,zcmp,jump,jump_alu mem=req,wr,sext,cal wb=reg_wr,ill
fff10093 1 ffffffff 0 0 1000 0000 0000 10  addi x1,x2,-1
80022193 1 fffff800 3 0 1000 0000 0000 10  slti x3,x4,-2048
0ff37293 1 000000ff 9 0 1000 0000 0000 10  andi x5,x6,255
00309093 1 00000003 2 0 1000 0000 0000 10  slli x1,x1,3
4041d113 1 00000404 7 0 1000 0000 0000 10  srai x2,x3,4
0041d113 1 00000004 6 0 1000 0000 0000 10  srli x2,x3,4
003100b3 1 00000000 0 0 1100 0000 0000 10  add x1,x2,x3
403100b3 1 00000000 1 0 1100 0000 0000 10  sub x1,x2,x3
4062d233 1 00000000 7 0 1100 0000 0000 10  sra x4,x5,x6
009463b3 1 00000000 8 0 1100 0000 0000 10  or x7,x8,x9
123452b7 1 12345000 8 0 0000 0000 0000 10  lui x5,0x12345
80000197 1 80000000 0 0 1011 0000 0000 10  auipc x3,0x80000
00410083 1 00000004 0 1 1000 0000 1011 10  lb x1,4(x2)
ffc11083 1 fffffffc 0 3 1000 0000 1011 10  lh x1,-4(x2)
00012083 1 00000000 0 f 1000 0000 1011 10  lw x1,0(x2)
00114083 1 00000001 0 1 1000 0000 1001 10  lbu x1,1(x2)
00215083 1 00000002 0 3 1000 0000 1001 10  lhu x1,2(x2)
003102a3 1 00000005 0 1 1000 0000 1100 00  sb x3,5(x2)
fe311c23 1 fffffff8 0 3 1000 0000 1100 00  sh x3,-8(x2)
7e312fa3 1 000007ff 0 f 1000 0000 1100 00  sw x3,2047(x2)
00208863 1 00000010 1 0 1100 1100 0000 00  beq x1,x2,16
fe209ee3 1 fffffffc 1 0 1100 1000 0000 00  bne x1,x2,-4
0041c0e3 1 00000800 3 0 1100 1000 0000 00  blt x3,x4,2048
8041d063 1 fffff000 3 0 1100 1100 0000 00  bge x3,x4,-4096
0062e463 1 00000008 4 0 1100 1000 0000 00  bltu x5,x6,8
0262f063 1 00000020 4 0 1100 1100 0000 00  bgeu x5,x6,32
678450ef 1 00045678 0 0 1101 0010 0000 10  jal x1,0x45678
fffff06f 1 fffffffe 0 0 1101 0010 0000 10  jal x0,-2
00c280e7 1 0000000c 0 0 1001 0001 0000 10  jalr x1,12(x5)
00510091 1 00000005 0 0 1000 0000 0000 01  addi with quadrant 01
00000073 1 00000000 0 0 0000 0000 0000 01  ecall, system opcode
0ff0000f 1 00000000 0 0 0000 0000 0000 01  fence
023100b3 1 00000000 0 0 1100 0000 0000 01  op with funct7 01
00013083 1 00000000 0 0 1000 0000 0001 01  load funct3 3
0020a063 1 00000000 0 0 1100 0000 0000 01  branch funct3 2
003100b3 0 00000000 0 0 0000 0000 0000 00  add with valid low

//--- dec_pkg.sv
`default_nettype none

package dec_pkg;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_OP_IMM = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_OP     = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // memory access size, expanded to byte strobes in the stage
    localparam logic [1:0] MEM_SIZE_B = 2'd0;
    localparam logic [1:0] MEM_SIZE_H = 2'd1;
    localparam logic [1:0] MEM_SIZE_W = 2'd2;

    localparam logic [2:0] FUNCT3_LB   = 3'd0;
    localparam logic [2:0] FUNCT3_LH   = 3'd1;
    localparam logic [2:0] FUNCT3_LW   = 3'd2;
    localparam logic [2:0] FUNCT3_LBU  = 3'd4;
    localparam logic [2:0] FUNCT3_LHU  = 3'd5;

    localparam logic [2:0] FUNCT3_SB   = 3'd0;
    localparam logic [2:0] FUNCT3_SH   = 3'd1;
    localparam logic [2:0] FUNCT3_SW   = 3'd2;

    localparam logic [2:0] FUNCT3_BEQ  = 3'd0;
    localparam logic [2:0] FUNCT3_BNE  = 3'd1;
    localparam logic [2:0] FUNCT3_BLT  = 3'd4;
    localparam logic [2:0] FUNCT3_BGE  = 3'd5;
    localparam logic [2:0] FUNCT3_BLTU = 3'd6;
    localparam logic [2:0] FUNCT3_BGEU = 3'd7;

    localparam logic [2:0] FUNCT3_ADD  = 3'd0; // also ADDI, SUB
    localparam logic [2:0] FUNCT3_SLL  = 3'd1;
    localparam logic [2:0] FUNCT3_SLT  = 3'd2;
    localparam logic [2:0] FUNCT3_SLTU = 3'd3;
    localparam logic [2:0] FUNCT3_XOR  = 3'd4;
    localparam logic [2:0] FUNCT3_SRL  = 3'd5; // also SRA
    localparam logic [2:0] FUNCT3_OR   = 3'd6;
    localparam logic [2:0] FUNCT3_AND  = 3'd7;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // bit 30, SUB / SRA

    // one instruction word, four ways to slice it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
            logic [1:0] quadrant;
        } r;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
            logic [1:0]  quadrant;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            opcode_e    opcode;
            logic [1:0] quadrant;
        } s;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            opcode_e     opcode;
            logic [1:0]  quadrant;
        } u;
    } inst_u;

endpackage

`default_nettype wire

//--- dec_stage.sv
`default_nettype none

module dec_stage import dec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic [31:0]       inst_i,
    input  logic              inst_valid_i,
    output logic              valid_o,
    output logic [XLEN-1:0]   imm_o,
    output alu_op_e           alu_op_o,
    output logic [XLEN/8-1:0] mem_byte_o,
    output logic              rs1_zero_sel_o,
    output logic              rs2_imm_sel_o,
    output logic              pc_imm_sel_o,
    output logic              pc_alu_sel_o,
    output logic              branch_o,
    output logic              branch_zcmp_o,
    output logic              jump_o,
    output logic              jump_alu_o,
    output logic              mem_req_o,
    output logic              mem_wr_o,
    output logic              mem_sign_ext_o,
    output logic              mem_cal_sel_o,
    output logic              reg_wr_o,
    output logic              ill_inst_o
);

    localparam int STRB_W = XLEN / 8;

    inst_u             inst;
    imm_fmt_e          imm_fmt;
    alu_op_e           alu_op;
    logic [1:0]        mem_size;
    logic [XLEN-1:0]   imm;
    logic [STRB_W-1:0] mem_byte;
    logic rs1_zero_sel, rs2_imm_sel, pc_imm_sel, pc_alu_sel;
    logic branch, branch_zcmp, jump, jump_alu;
    logic mem_req, mem_wr, mem_sign_ext, mem_cal_sel, reg_wr, ill_inst;

    assign inst = inst_u'(inst_i);

    dec_ctrl u_ctrl (
        .inst_i         (inst),
        .inst_valid_i   (inst_valid_i),
        .imm_fmt_o      (imm_fmt),
        .alu_op_o       (alu_op),
        .mem_size_o     (mem_size),
        .rs1_zero_sel_o (rs1_zero_sel),
        .rs2_imm_sel_o  (rs2_imm_sel),
        .pc_imm_sel_o   (pc_imm_sel),
        .pc_alu_sel_o   (pc_alu_sel),
        .branch_o       (branch),
        .branch_zcmp_o  (branch_zcmp),
        .jump_o         (jump),
        .jump_alu_o     (jump_alu),
        .mem_req_o      (mem_req),
        .mem_wr_o       (mem_wr),
        .mem_sign_ext_o (mem_sign_ext),
        .mem_cal_sel_o  (mem_cal_sel),
        .reg_wr_o       (reg_wr),
        .ill_inst_o     (ill_inst)
    );

    dec_imm #(.XLEN(XLEN)) u_imm (
        .inst_i    (inst),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    always_comb begin
        mem_byte = '0;
        if (mem_req) begin
            case (mem_size)
                MEM_SIZE_B: mem_byte = STRB_W'(4'b0001);
                MEM_SIZE_H: mem_byte = STRB_W'(4'b0011);
                default:    mem_byte = STRB_W'(4'b1111); // word
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o        <= 1'b0;
            alu_op_o       <= ALU_ADD;
            mem_byte_o     <= '0;
            rs1_zero_sel_o <= 1'b0;
            rs2_imm_sel_o  <= 1'b0;
            pc_imm_sel_o   <= 1'b0;
            pc_alu_sel_o   <= 1'b0;
            branch_o       <= 1'b0;
            branch_zcmp_o  <= 1'b0;
            jump_o         <= 1'b0;
            jump_alu_o     <= 1'b0;
            mem_req_o      <= 1'b0;
            mem_wr_o       <= 1'b0;
            mem_sign_ext_o <= 1'b0;
            mem_cal_sel_o  <= 1'b0;
            reg_wr_o       <= 1'b0;
            ill_inst_o     <= 1'b0;
        end else begin
            valid_o        <= inst_valid_i;
            alu_op_o       <= alu_op;
            mem_byte_o     <= ill_inst ? '0 : mem_byte; // trapped op touches nothing
            rs1_zero_sel_o <= rs1_zero_sel;
            rs2_imm_sel_o  <= rs2_imm_sel;
            pc_imm_sel_o   <= pc_imm_sel;
            pc_alu_sel_o   <= pc_alu_sel;
            branch_o       <= branch & ~ill_inst;
            branch_zcmp_o  <= branch_zcmp;
            jump_o         <= jump & ~ill_inst;
            jump_alu_o     <= jump_alu & ~ill_inst;
            mem_req_o      <= mem_req & ~ill_inst;
            mem_wr_o       <= mem_wr & ~ill_inst;
            mem_sign_ext_o <= mem_sign_ext;
            mem_cal_sel_o  <= mem_cal_sel;
            reg_wr_o       <= reg_wr & ~ill_inst;
            ill_inst_o     <= ill_inst;
        end
    end

    always_ff @(posedge clk) begin
        imm_o <= imm; // zero when idle, fmt is none
    end

    a_wr_has_req: assert property (@(posedge clk) disable iff (reset_i)
        mem_wr_o |-> mem_req_o);

    a_one_jump: assert property (@(posedge clk) disable iff (reset_i)
        !(jump_o && jump_alu_o));

    a_ill_no_wb: assert property (@(posedge clk) disable iff (reset_i)
        ill_inst_o |-> !reg_wr_o);

    // an idle slot carries no control and no data
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset_i)
        !valid_o |-> !(reg_wr_o || mem_req_o || mem_wr_o || branch_o || jump_o ||
                       jump_alu_o || ill_inst_o || rs1_zero_sel_o || rs2_imm_sel_o ||
                       pc_imm_sel_o || pc_alu_sel_o || branch_zcmp_o || mem_sign_ext_o ||
                       mem_cal_sel_o || (|mem_byte_o) || (|imm_o) ||
                       (alu_op_o != ALU_ADD)));

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
dec_pkg.sv
dec_imm.sv
dec_ctrl.sv
dec_stage.sv
tb_dec.sv

//--- tb_dec_checks.svh
`ifndef TB_DEC_CHECKS_SVH
`define TB_DEC_CHECKS_SVH

// 32-bit xorshift, drives idle gaps and junk words
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (act !== exp) begin
        $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
        $display("error at %0d ns: %s expected %s (%0d), got %s (%0d)",
                 $time, name, exp.name(), exp, act.name(), act);
        abort_run();
    end
endtask

task automatic check_strb(input string name, input logic [STRB_W-1:0] exp,
                          input logic [STRB_W-1:0] act);
    if (act !== exp) begin
        $display("error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
        abort_run();
    end
endtask

`endif

//--- tb_dec.sv
`default_nettype none

module tb_dec import dec_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int XLEN    = 32;
    localparam int STRB_W  = XLEN / 8;
    localparam int MAX_PAT = 64;

    logic              clk = 1'b0;
    logic              reset_i;
    logic [31:0]       inst_i;
    logic              inst_valid_i;
    logic              valid_o;
    logic [XLEN-1:0]   imm_o;
    alu_op_e           alu_op_o;
    logic [STRB_W-1:0] mem_byte_o;
    logic rs1_zero_sel_o, rs2_imm_sel_o, pc_imm_sel_o, pc_alu_sel_o;
    logic branch_o, branch_zcmp_o, jump_o, jump_alu_o;
    logic mem_req_o, mem_wr_o, mem_sign_ext_o, mem_cal_sel_o, reg_wr_o, ill_inst_o;

    logic [31:0]       pat_inst  [MAX_PAT];
    logic              pat_valid [MAX_PAT];
    logic [XLEN-1:0]   pat_imm   [MAX_PAT];
    alu_op_e           pat_alu   [MAX_PAT];
    logic [STRB_W-1:0] pat_strb  [MAX_PAT];
    logic [3:0]        pat_sel   [MAX_PAT]; // rs1_zero, rs2_imm, pc_imm, pc_alu
    logic [3:0]        pat_xfer  [MAX_PAT]; // branch, zcmp, jump, jump_alu
    logic [3:0]        pat_mem   [MAX_PAT]; // req, wr, sign_ext, cal_sel
    logic [1:0]        pat_wb    [MAX_PAT]; // reg_wr, ill_inst

    int          n_pat       = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    int          exp_q[$];           // pattern index per drive slot, -1 is idle
    logic [31:0] rand_state;

    dec_stage #(.XLEN(XLEN)) dut_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_i         (inst_i),
        .inst_valid_i   (inst_valid_i),
        .valid_o        (valid_o),
        .imm_o          (imm_o),
        .alu_op_o       (alu_op_o),
        .mem_byte_o     (mem_byte_o),
        .rs1_zero_sel_o (rs1_zero_sel_o),
        .rs2_imm_sel_o  (rs2_imm_sel_o),
        .pc_imm_sel_o   (pc_imm_sel_o),
        .pc_alu_sel_o   (pc_alu_sel_o),
        .branch_o       (branch_o),
        .branch_zcmp_o  (branch_zcmp_o),
        .jump_o         (jump_o),
        .jump_alu_o     (jump_alu_o),
        .mem_req_o      (mem_req_o),
        .mem_wr_o       (mem_wr_o),
        .mem_sign_ext_o (mem_sign_ext_o),
        .mem_cal_sel_o  (mem_cal_sel_o),
        .reg_wr_o       (reg_wr_o),
        .ill_inst_o     (ill_inst_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: pattern stream did not finish");
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic load_patterns();
        int                fd;
        int                got;
        string             line;
        logic [31:0]       f_inst;
        logic              f_valid;
        logic [XLEN-1:0]   f_imm;
        logic [3:0]        f_alu;
        logic [STRB_W-1:0] f_strb;
        logic [3:0]        f_sel;
        logic [3:0]        f_xfer;
        logic [3:0]        f_mem;
        logic [1:0]        f_wb;
        fd = $fopen("dec_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open dec_patterns.txt");
            abort_run();
        end
        while (!$feof(fd) && n_pat < MAX_PAT) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%h %b %h %h %h %b %b %b %b", f_inst, f_valid, f_imm,
                              f_alu, f_strb, f_sel, f_xfer, f_mem, f_wb);
                if (got != 9) begin
                    $display("malformed line in dec_patterns.txt: %s", line);
                    abort_run();
                end
                pat_inst[n_pat]  = f_inst;
                pat_valid[n_pat] = f_valid;
                pat_imm[n_pat]   = f_imm;
                pat_alu[n_pat]   = alu_op_e'(f_alu);
                pat_strb[n_pat]  = f_strb;
                pat_sel[n_pat]   = f_sel;
                pat_xfer[n_pat]  = f_xfer;
                pat_mem[n_pat]   = f_mem;
                pat_wb[n_pat]    = f_wb;
                n_pat++;
            end
        end
        $fclose(fd);
        if (n_pat == 0) begin
            $display("dec_patterns.txt holds no patterns");
            abort_run();
        end
    endtask

    task automatic check_outputs(input int idx);
        logic              e_valid;
        logic [XLEN-1:0]   e_imm;
        alu_op_e           e_alu;
        logic [STRB_W-1:0] e_strb;
        logic [3:0]        e_sel;
        logic [3:0]        e_xfer;
        logic [3:0]        e_mem;
        logic [1:0]        e_wb;
        if (idx < 0) begin   // idle slot, everything quiet
            e_valid = 1'b0;
            e_imm   = '0;
            e_alu   = ALU_ADD;
            e_strb  = '0;
            e_sel   = '0;
            e_xfer  = '0;
            e_mem   = '0;
            e_wb    = '0;
        end else begin
            e_valid = pat_valid[idx];
            e_imm   = pat_imm[idx];
            e_alu   = pat_alu[idx];
            e_strb  = pat_strb[idx];
            e_sel   = pat_sel[idx];
            e_xfer  = pat_xfer[idx];
            e_mem   = pat_mem[idx];
            e_wb    = pat_wb[idx];
        end
        check_bit("valid_o", e_valid, valid_o);
        check_word("imm_o", e_imm, imm_o);
        check_alu("alu_op_o", e_alu, alu_op_o);
        check_strb("mem_byte_o", e_strb, mem_byte_o);
        check_bit("rs1_zero_sel_o", e_sel[3], rs1_zero_sel_o);
        check_bit("rs2_imm_sel_o", e_sel[2], rs2_imm_sel_o);
        check_bit("pc_imm_sel_o", e_sel[1], pc_imm_sel_o);
        check_bit("pc_alu_sel_o", e_sel[0], pc_alu_sel_o);
        check_bit("branch_o", e_xfer[3], branch_o);
        check_bit("branch_zcmp_o", e_xfer[2], branch_zcmp_o);
        check_bit("jump_o", e_xfer[1], jump_o);
        check_bit("jump_alu_o", e_xfer[0], jump_alu_o);
        check_bit("mem_req_o", e_mem[3], mem_req_o);
        check_bit("mem_wr_o", e_mem[2], mem_wr_o);
        check_bit("mem_sign_ext_o", e_mem[1], mem_sign_ext_o);
        check_bit("mem_cal_sel_o", e_mem[0], mem_cal_sel_o);
        check_bit("reg_wr_o", e_wb[1], reg_wr_o);
        check_bit("ill_inst_o", e_wb[0], ill_inst_o);
    endtask

    // result of a slot shows up one edge later, checked on the falling edge
    task automatic drive_slot(input logic [31:0] inst, input logic valid, input int idx);
        @(posedge clk);
        inst_i       <= inst;
        inst_valid_i <= valid;
        exp_q.push_back(idx);
        @(negedge clk);
        if (exp_q.size() > 1) check_outputs(exp_q.pop_front());
    endtask

    initial begin
        int gap;
        reset_i      <= 1'b1;
        inst_i       <= '0;
        inst_valid_i <= 1'b0;
        rand_state   = 32'h4a93;
        load_patterns();
        cycle_limit = 16 + 5 * n_pat + 20;

        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) reset_i <= 1'b0;
            @(negedge clk);
            check_outputs(-1);
        end
        exp_q.push_back(-1); // first edge out of reset is still idle

        for (int p = 0; p < n_pat; p++) begin
            drive_slot(pat_inst[p], pat_valid[p], p);
            rand_state = xorshift32(rand_state);
            gap        = int'(rand_state[1:0]);
            repeat (gap) begin
                rand_state = xorshift32(rand_state);
                drive_slot(rand_state, 1'b0, -1); // junk word, valid low
            end
        end

        // same stream again, one instruction per cycle
        for (int p = 0; p < n_pat; p++) begin
            drive_slot(pat_inst[p], pat_valid[p], p);
        end
        drive_slot(32'h0, 1'b0, -1);

        $display("Result: PASSED");
        $finish;
    end

    `include "tb_dec_checks.svh"

endmodule

`default_nettype wire
